// File: source/id_pkg.sv
package id_pkg;

	localparam int DATA_W         = 32;
	localparam int REG_ADDR_W     = 5;
	localparam int PC_NEXT_OFFSET = 4;
	localparam int PC_LINK_OFFSET = 8;

	typedef logic [DATA_W-1:0]     word_t;
	typedef logic [REG_ADDR_W-1:0] reg_addr_t;

	// return address register for the linking jumps
	localparam reg_addr_t LINK_REG = 5'd31;

	//////////////////////////////////////////////////
	// instruction encodings
	//////////////////////////////////////////////////

	typedef enum logic [5:0] {
		OP_SPECIAL = 6'b000000, OP_REGIMM = 6'b000001,
		OP_J       = 6'b000010, OP_JAL    = 6'b000011,
		OP_BEQ     = 6'b000100, OP_BNE    = 6'b000101,
		OP_BLEZ    = 6'b000110, OP_BGTZ   = 6'b000111,
		OP_ADDI    = 6'b001000, OP_ADDIU  = 6'b001001,
		OP_SLTI    = 6'b001010, OP_SLTIU  = 6'b001011,
		OP_ANDI    = 6'b001100, OP_ORI    = 6'b001101,
		OP_XORI    = 6'b001110, OP_LUI    = 6'b001111,
		OP_LB      = 6'b100000, OP_LW     = 6'b100011,
		OP_LBU     = 6'b100100, OP_SB     = 6'b101000,
		OP_SW      = 6'b101011
	} opcode_e;

	typedef enum logic [5:0] {
		FN_SLL  = 6'b000000, FN_SRL  = 6'b000010, FN_SRA  = 6'b000011,
		FN_SLLV = 6'b000100, FN_SRLV = 6'b000110, FN_SRAV = 6'b000111,
		FN_JR   = 6'b001000, FN_JALR = 6'b001001,
		FN_ADD  = 6'b100000, FN_ADDU = 6'b100001,
		FN_SUB  = 6'b100010, FN_SUBU = 6'b100011,
		FN_AND  = 6'b100100, FN_OR   = 6'b100101,
		FN_XOR  = 6'b100110, FN_NOR  = 6'b100111,
		FN_SLT  = 6'b101010, FN_SLTU = 6'b101011
	} funct_e;

	// rt field codes under REGIMM
	typedef enum logic [4:0] {
		RI_BLTZ   = 5'b00000, RI_BGEZ   = 5'b00001,
		RI_BLTZAL = 5'b10000, RI_BGEZAL = 5'b10001
	} regimm_e;

	//////////////////////////////////////////////////
	// execute-side operation codes
	//////////////////////////////////////////////////

	typedef enum logic [7:0] {
		ALU_NOP   = 8'b0000_0000,
		ALU_AND   = 8'b0010_0100, ALU_OR    = 8'b0010_0101,
		ALU_XOR   = 8'b0010_0110, ALU_NOR   = 8'b0010_0111,
		ALU_ANDI  = 8'b0101_1001, ALU_ORI   = 8'b0101_1010,
		ALU_XORI  = 8'b0101_1011, ALU_LUI   = 8'b0101_1100,
		ALU_SLL   = 8'b0111_1100, ALU_SRL   = 8'b0000_0010,
		ALU_SRA   = 8'b0000_0011, ALU_SLLV  = 8'b0000_0100,
		ALU_SRLV  = 8'b0000_0110, ALU_SRAV  = 8'b0000_0111,
		ALU_ADD   = 8'b0010_0000, ALU_ADDU  = 8'b0010_0001,
		ALU_SUB   = 8'b0010_0010, ALU_SUBU  = 8'b0010_0011,
		ALU_SLT   = 8'b0010_1010, ALU_SLTU  = 8'b0010_1011,
		ALU_ADDI  = 8'b0101_0101, ALU_ADDIU = 8'b0101_0110,
		ALU_SLTI  = 8'b0101_0111, ALU_SLTIU = 8'b0101_1000,
		ALU_J     = 8'b0100_1111, ALU_JAL   = 8'b0101_0000,
		ALU_JR    = 8'b0000_1000, ALU_JALR  = 8'b0000_1001,
		ALU_BEQ   = 8'b0101_0001, ALU_BNE   = 8'b0101_0010,
		ALU_BLEZ  = 8'b0101_0011, ALU_BGTZ  = 8'b0101_0100,
		ALU_BLTZ  = 8'b0100_0000, ALU_BGEZ  = 8'b0100_0001,
		ALU_BLTZAL = 8'b0100_1010, ALU_BGEZAL = 8'b0100_1011,
		ALU_LB    = 8'b1110_0000, ALU_LBU   = 8'b1110_0100,
		ALU_LW    = 8'b1110_0011, ALU_SB    = 8'b1110_1000,
		ALU_SW    = 8'b1110_1011
	} alu_op_e;

	// result class, picks the EX output mux
	typedef enum logic [2:0] {
		SEL_NOP         = 3'b000,
		SEL_LOGIC       = 3'b001,
		SEL_SHIFT       = 3'b010,
		SEL_ARITH       = 3'b100,
		SEL_JUMP_BRANCH = 3'b110,
		SEL_LOAD_STORE  = 3'b111
	} alu_sel_e;

	//////////////////////////////////////////////////
	// stage bundles
	//////////////////////////////////////////////////

	typedef struct packed {
		logic      we;
		reg_addr_t waddr;
		word_t     wdata;
	} fwd_t;

	typedef struct packed {
		alu_op_e   alu_op;
		alu_sel_e  alu_sel;
		logic      reg1_read;
		reg_addr_t reg1_addr;
		logic      reg2_read;
		reg_addr_t reg2_addr;
		reg_addr_t waddr;
		logic      we;
		word_t     imm;
		logic      invalid;
	} dec_ctrl_t;

	typedef struct packed {
		logic  flag;
		word_t target;
		word_t link_addr;
		logic  next_in_delayslot;
	} branch_t;

	typedef struct packed {
		alu_op_e   alu_op;
		alu_sel_e  alu_sel;
		word_t     reg1;
		word_t     reg2;
		reg_addr_t waddr;
		logic      we;
		word_t     link_addr;
		logic      in_delayslot;
		logic      invalid;
		word_t     inst;
	} id_ex_t;

endpackage

// File: source/inst_decoder.sv
module inst_decoder (
	input  id_pkg::word_t     inst_i,
	output id_pkg::dec_ctrl_t dec_o
);

	import id_pkg::*;

	opcode_e   opcode;
	funct_e    funct;
	regimm_e   rimm;
	reg_addr_t rs;
	reg_addr_t rt;
	reg_addr_t rd;
	word_t     imm_zext;
	word_t     imm_sext;
	word_t     imm_upper;
	word_t     imm_shamt;

	// instruction fields
	assign opcode = opcode_e'(inst_i[31:26]);
	assign funct  = funct_e'(inst_i[5:0]);
	assign rimm   = regimm_e'(inst_i[20:16]);
	assign rs     = inst_i[25:21];
	assign rt     = inst_i[20:16];
	assign rd     = inst_i[15:11];

	// immediate forms
	assign imm_zext  = {16'h0000, inst_i[15:0]};
	assign imm_sext  = {{16{inst_i[15]}}, inst_i[15:0]};
	assign imm_upper = {inst_i[15:0], 16'h0000};
	assign imm_shamt = {27'd0, inst_i[10:6]};

	// fills in the class of a recognised instruction
	function automatic dec_ctrl_t set_class(
		input dec_ctrl_t d,
		input alu_op_e   op,
		input alu_sel_e  sel,
		input logic      rd1,
		input logic      rd2,
		input logic      we
	);
		d.alu_op    = op;
		d.alu_sel   = sel;
		d.reg1_read = rd1;
		d.reg2_read = rd2;
		d.we        = we;
		d.invalid   = 1'b0;
		return d;
	endfunction

	always_comb begin
		dec_o           = '0;
		dec_o.alu_op    = ALU_NOP;
		dec_o.alu_sel   = SEL_NOP;
		dec_o.reg1_addr = rs;
		dec_o.reg2_addr = rt;
		// R-type writes rd, the rest write rt
		dec_o.waddr     = (opcode == OP_SPECIAL) ? rd : rt;
		dec_o.invalid   = 1'b1;

		case (opcode)
			OP_SPECIAL: begin
				case (funct)
					FN_AND:  dec_o = set_class(dec_o, ALU_AND, SEL_LOGIC, 1'b1, 1'b1, 1'b1);
					FN_OR:   dec_o = set_class(dec_o, ALU_OR, SEL_LOGIC, 1'b1, 1'b1, 1'b1);
					FN_XOR:  dec_o = set_class(dec_o, ALU_XOR, SEL_LOGIC, 1'b1, 1'b1, 1'b1);
					FN_NOR:  dec_o = set_class(dec_o, ALU_NOR, SEL_LOGIC, 1'b1, 1'b1, 1'b1);
					FN_SLLV: dec_o = set_class(dec_o, ALU_SLLV, SEL_SHIFT, 1'b1, 1'b1, 1'b1);
					FN_SRLV: dec_o = set_class(dec_o, ALU_SRLV, SEL_SHIFT, 1'b1, 1'b1, 1'b1);
					FN_SRAV: dec_o = set_class(dec_o, ALU_SRAV, SEL_SHIFT, 1'b1, 1'b1, 1'b1);
					FN_ADD:  dec_o = set_class(dec_o, ALU_ADD, SEL_ARITH, 1'b1, 1'b1, 1'b1);
					FN_ADDU: dec_o = set_class(dec_o, ALU_ADDU, SEL_ARITH, 1'b1, 1'b1, 1'b1);
					FN_SUB:  dec_o = set_class(dec_o, ALU_SUB, SEL_ARITH, 1'b1, 1'b1, 1'b1);
					FN_SUBU: dec_o = set_class(dec_o, ALU_SUBU, SEL_ARITH, 1'b1, 1'b1, 1'b1);
					FN_SLT:  dec_o = set_class(dec_o, ALU_SLT, SEL_ARITH, 1'b1, 1'b1, 1'b1);
					FN_SLTU: dec_o = set_class(dec_o, ALU_SLTU, SEL_ARITH, 1'b1, 1'b1, 1'b1);
					// immediate shifts take rt on port 2 and shamt in place of rs
					FN_SLL: begin
						dec_o     = set_class(dec_o, ALU_SLL, SEL_SHIFT, 1'b0, 1'b1, 1'b1);
						dec_o.imm = imm_shamt;
					end
					FN_SRL: begin
						dec_o     = set_class(dec_o, ALU_SRL, SEL_SHIFT, 1'b0, 1'b1, 1'b1);
						dec_o.imm = imm_shamt;
					end
					FN_SRA: begin
						dec_o     = set_class(dec_o, ALU_SRA, SEL_SHIFT, 1'b0, 1'b1, 1'b1);
						dec_o.imm = imm_shamt;
					end
					FN_JR:   dec_o = set_class(dec_o, ALU_JR, SEL_JUMP_BRANCH, 1'b1, 1'b0, 1'b0);
					FN_JALR: dec_o = set_class(dec_o, ALU_JALR, SEL_JUMP_BRANCH, 1'b1, 1'b0, 1'b1);
					default: ;
				endcase
			end
			OP_REGIMM: begin
				case (rimm)
					RI_BLTZ: dec_o = set_class(dec_o, ALU_BLTZ, SEL_JUMP_BRANCH, 1'b1, 1'b0, 1'b0);
					RI_BGEZ: dec_o = set_class(dec_o, ALU_BGEZ, SEL_JUMP_BRANCH, 1'b1, 1'b0, 1'b0);
					RI_BLTZAL: begin
						dec_o = set_class(dec_o, ALU_BLTZAL, SEL_JUMP_BRANCH, 1'b1, 1'b0, 1'b1);
						dec_o.waddr = LINK_REG;
					end
					RI_BGEZAL: begin
						dec_o = set_class(dec_o, ALU_BGEZAL, SEL_JUMP_BRANCH, 1'b1, 1'b0, 1'b1);
						dec_o.waddr = LINK_REG;
					end
					default: ;
				endcase
			end
			OP_J: dec_o = set_class(dec_o, ALU_J, SEL_JUMP_BRANCH, 1'b0, 1'b0, 1'b0);
			OP_JAL: begin
				dec_o       = set_class(dec_o, ALU_JAL, SEL_JUMP_BRANCH, 1'b0, 1'b0, 1'b1);
				dec_o.waddr = LINK_REG;
			end
			OP_BEQ:  dec_o = set_class(dec_o, ALU_BEQ, SEL_JUMP_BRANCH, 1'b1, 1'b1, 1'b0);
			OP_BNE:  dec_o = set_class(dec_o, ALU_BNE, SEL_JUMP_BRANCH, 1'b1, 1'b1, 1'b0);
			OP_BLEZ: dec_o = set_class(dec_o, ALU_BLEZ, SEL_JUMP_BRANCH, 1'b1, 1'b0, 1'b0);
			OP_BGTZ: dec_o = set_class(dec_o, ALU_BGTZ, SEL_JUMP_BRANCH, 1'b1, 1'b0, 1'b0);
			// logic immediates are zero extended
			OP_ANDI: begin
				dec_o     = set_class(dec_o, ALU_ANDI, SEL_LOGIC, 1'b1, 1'b0, 1'b1);
				dec_o.imm = imm_zext;
			end
			OP_ORI: begin
				dec_o     = set_class(dec_o, ALU_ORI, SEL_LOGIC, 1'b1, 1'b0, 1'b1);
				dec_o.imm = imm_zext;
			end
			OP_XORI: begin
				dec_o     = set_class(dec_o, ALU_XORI, SEL_LOGIC, 1'b1, 1'b0, 1'b1);
				dec_o.imm = imm_zext;
			end
			OP_LUI: begin
				dec_o     = set_class(dec_o, ALU_LUI, SEL_LOGIC, 1'b1, 1'b0, 1'b1);
				dec_o.imm = imm_upper;
			end
			// arithmetic immediates are sign extended, SLTIU included
			OP_ADDI: begin
				dec_o     = set_class(dec_o, ALU_ADDI, SEL_ARITH, 1'b1, 1'b0, 1'b1);
				dec_o.imm = imm_sext;
			end
			OP_ADDIU: begin
				dec_o     = set_class(dec_o, ALU_ADDIU, SEL_ARITH, 1'b1, 1'b0, 1'b1);
				dec_o.imm = imm_sext;
			end
			OP_SLTI: begin
				dec_o     = set_class(dec_o, ALU_SLTI, SEL_ARITH, 1'b1, 1'b0, 1'b1);
				dec_o.imm = imm_sext;
			end
			OP_SLTIU: begin
				dec_o     = set_class(dec_o, ALU_SLTIU, SEL_ARITH, 1'b1, 1'b0, 1'b1);
				dec_o.imm = imm_sext;
			end
			OP_LB:  dec_o = set_class(dec_o, ALU_LB, SEL_LOAD_STORE, 1'b1, 1'b0, 1'b1);
			OP_LBU: dec_o = set_class(dec_o, ALU_LBU, SEL_LOAD_STORE, 1'b1, 1'b0, 1'b1);
			OP_LW:  dec_o = set_class(dec_o, ALU_LW, SEL_LOAD_STORE, 1'b1, 1'b0, 1'b1);
			OP_SB:  dec_o = set_class(dec_o, ALU_SB, SEL_LOAD_STORE, 1'b1, 1'b1, 1'b0);
			OP_SW:  dec_o = set_class(dec_o, ALU_SW, SEL_LOAD_STORE, 1'b1, 1'b1, 1'b0);
			// anything else stays an invalid NOP
			default: ;
		endcase
	end

endmodule

// File: source/operand_bypass.sv
module operand_bypass (
	input  id_pkg::dec_ctrl_t dec_i,
	input  id_pkg::word_t     reg1_data_i,
	input  id_pkg::word_t     reg2_data_i,
	input  id_pkg::fwd_t      ex_fwd_i,
	input  id_pkg::fwd_t      mem_fwd_i,
	input  id_pkg::alu_op_e   ex_aluop_i,
	output id_pkg::word_t     reg1_o,
	output id_pkg::word_t     reg2_o,
	output logic              stall_o
);

	import id_pkg::*;

	logic ex_is_load;
	logic load_hit1;
	logic load_hit2;

	// EX result is newest, then MEM, then the register file
	function automatic word_t select_operand(
		input logic      rd_en,
		input reg_addr_t addr,
		input word_t     rf_data,
		input word_t     imm,
		input fwd_t      ex_fwd,
		input fwd_t      mem_fwd
	);
		word_t res;
		if (!rd_en) begin
			res = imm;
		end else if (ex_fwd.we && (ex_fwd.waddr == addr)) begin
			res = ex_fwd.wdata;
		end else if (mem_fwd.we && (mem_fwd.waddr == addr)) begin
			res = mem_fwd.wdata;
		end else begin
			res = rf_data;
		end
		return res;
	endfunction

	function automatic logic ex_dest_hit(
		input logic      rd_en,
		input reg_addr_t addr,
		input fwd_t      ex_fwd
	);
		return rd_en && ex_fwd.we && (ex_fwd.waddr == addr);
	endfunction

	assign reg1_o = select_operand(dec_i.reg1_read, dec_i.reg1_addr, reg1_data_i,
		dec_i.imm, ex_fwd_i, mem_fwd_i);
	assign reg2_o = select_operand(dec_i.reg2_read, dec_i.reg2_addr, reg2_data_i,
		dec_i.imm, ex_fwd_i, mem_fwd_i);

	//////////////////////////////////////////////////
	// load-use hazard
	//////////////////////////////////////////////////

	// load data is not ready until MEM, so the EX path cannot supply it
	assign ex_is_load = ex_aluop_i inside {ALU_LB, ALU_LBU, ALU_LW};
	assign load_hit1  = ex_dest_hit(dec_i.reg1_read, dec_i.reg1_addr, ex_fwd_i);
	assign load_hit2  = ex_dest_hit(dec_i.reg2_read, dec_i.reg2_addr, ex_fwd_i);
	assign stall_o    = ex_is_load && (load_hit1 || load_hit2);

endmodule

// File: source/branch_resolver.sv
module branch_resolver (
	input  id_pkg::dec_ctrl_t dec_i,
	input  id_pkg::word_t     inst_i,
	input  id_pkg::word_t     pc_i,
	input  id_pkg::word_t     reg1_i,
	input  id_pkg::word_t     reg2_i,
	output id_pkg::branch_t   branch_o
);

	import id_pkg::*;

	word_t pc_plus4;
	word_t pc_plus8;
	word_t jump_target;
	word_t cond_target;
	word_t target;
	logic  taken;
	logic  is_link;

	assign pc_plus4 = pc_i + word_t'(PC_NEXT_OFFSET);
	assign pc_plus8 = pc_i + word_t'(PC_LINK_OFFSET);

	// region of the delay slot plus the 26-bit index
	assign jump_target = {pc_plus4[31:28], inst_i[25:0], 2'b00};
	assign cond_target = pc_plus4 + {{14{inst_i[15]}}, inst_i[15:0], 2'b00};

	always_comb begin
		taken  = 1'b0;
		target = cond_target;
		case (dec_i.alu_op)
			ALU_J, ALU_JAL: begin
				taken  = 1'b1;
				target = jump_target;
			end
			ALU_JR, ALU_JALR: begin
				taken  = 1'b1;
				target = reg1_i;
			end
			ALU_BEQ:              taken = (reg1_i == reg2_i);
			ALU_BNE:              taken = (reg1_i != reg2_i);
			ALU_BGTZ:             taken = ($signed(reg1_i) > 32'sd0);
			ALU_BLEZ:             taken = ($signed(reg1_i) <= 32'sd0);
			ALU_BGEZ, ALU_BGEZAL: taken = ~reg1_i[31];
			ALU_BLTZ, ALU_BLTZAL: taken = reg1_i[31];
			default:              taken = 1'b0;
		endcase
	end

	// link is written whether or not the branch is taken
	assign is_link = dec_i.alu_op inside {ALU_JAL, ALU_JALR, ALU_BGEZAL, ALU_BLTZAL};

	assign branch_o = '{
		flag:              taken,
		target:            taken ? target : '0,
		link_addr:         is_link ? pc_plus8 : '0,
		next_in_delayslot: taken
	};

endmodule

// File: source/id_stage.sv
module id_stage (
	input  logic              clk,
	input  logic              rst_n_i,

	// instruction from IF
	input  logic              inst_valid_i,
	input  id_pkg::word_t     inst_i,
	input  id_pkg::word_t     pc_i,
	input  logic              in_delayslot_i,

	// register file
	output logic              reg1_read_o,
	output id_pkg::reg_addr_t reg1_addr_o,
	output logic              reg2_read_o,
	output id_pkg::reg_addr_t reg2_addr_o,
	input  id_pkg::word_t     reg1_data_i,
	input  id_pkg::word_t     reg2_data_i,

	// forwarding and hazard inputs
	input  id_pkg::fwd_t      ex_fwd_i,
	input  id_pkg::fwd_t      mem_fwd_i,
	input  id_pkg::alu_op_e   ex_aluop_i,

	output id_pkg::branch_t   branch_o,
	output logic              stall_o,

	// ID/EX register
	output logic              ex_valid_o,
	output id_pkg::id_ex_t    ex_o
);

	import id_pkg::*;

	dec_ctrl_t dec;
	word_t     opnd1;
	word_t     opnd2;
	branch_t   br_raw;
	id_ex_t    ex_next;
	logic      accept;

	inst_decoder u_decoder (
		.inst_i (inst_i),
		.dec_o  (dec)
	);

	operand_bypass u_bypass (
		.dec_i       (dec),
		.reg1_data_i (reg1_data_i),
		.reg2_data_i (reg2_data_i),
		.ex_fwd_i    (ex_fwd_i),
		.mem_fwd_i   (mem_fwd_i),
		.ex_aluop_i  (ex_aluop_i),
		.reg1_o      (opnd1),
		.reg2_o      (opnd2),
		.stall_o     (stall_o)
	);

	branch_resolver u_branch (
		.dec_i    (dec),
		.inst_i   (inst_i),
		.pc_i     (pc_i),
		.reg1_i   (opnd1),
		.reg2_i   (opnd2),
		.branch_o (br_raw)
	);

	assign reg1_read_o = dec.reg1_read;
	assign reg1_addr_o = dec.reg1_addr;
	assign reg2_read_o = dec.reg2_read;
	assign reg2_addr_o = dec.reg2_addr;

	// a stalled strobe is replayed, so it must not redirect fetch
	assign accept = inst_valid_i && !stall_o;

	always_comb begin
		branch_o                   = br_raw;
		branch_o.flag              = br_raw.flag && accept;
		branch_o.next_in_delayslot = br_raw.next_in_delayslot && accept;
	end

	//////////////////////////////////////////////////
	// ID/EX register
	//////////////////////////////////////////////////

	always_comb begin
		ex_next.alu_op       = dec.alu_op;
		ex_next.alu_sel      = dec.alu_sel;
		ex_next.reg1         = opnd1;
		ex_next.reg2         = opnd2;
		ex_next.waddr        = dec.waddr;
		ex_next.we           = dec.we;
		ex_next.link_addr    = br_raw.link_addr;
		ex_next.in_delayslot = in_delayslot_i;
		ex_next.invalid      = dec.invalid;
		ex_next.inst         = inst_i;
	end

	// bubble on stall or idle cycle
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			ex_valid_o <= 1'b0;
		end else begin
			ex_valid_o <= accept;
		end
	end

	// payload holds between accepted strobes
	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			ex_o <= '0;
		end else if (accept) begin
			ex_o <= ex_next;
		end
	end

endmodule

// File: bench/id_stage_chk.sv
module id_stage_chk (
	input logic                clk,
	input logic                rst_n_i,
	input logic                inst_valid_i,
	input logic                stall_o,
	input id_pkg::branch_t     branch_o,
	input logic                ex_valid_o
);
	timeunit 1ns;
	timeprecision 100ps;

	// failed assertions so far
	int unsigned fail_count = 0;

	// ID/EX valid only follows a strobe
	a_valid_after_strobe: assert property (@(posedge clk) disable iff (!rst_n_i)
		ex_valid_o |-> $past(inst_valid_i))
	else begin
		fail_count++;
		$error("ex_valid_o high without a strobe in the previous cycle");
	end

	a_flag_needs_strobe: assert property (@(posedge clk) disable iff (!rst_n_i)
		branch_o.flag |-> inst_valid_i)
	else begin
		fail_count++;
		$error("branch flag high without a strobe");
	end

	// stalled strobe leaves a bubble
	a_bubble_on_stall: assert property (@(posedge clk) disable iff (!rst_n_i)
		(inst_valid_i && stall_o) |=> !ex_valid_o)
	else begin
		fail_count++;
		$error("ex_valid_o high after a stalled strobe");
	end

endmodule

bind id_stage id_stage_chk u_chk (
	.clk          (clk),
	.rst_n_i      (rst_n_i),
	.inst_valid_i (inst_valid_i),
	.stall_o      (stall_o),
	.branch_o     (branch_o),
	.ex_valid_o   (ex_valid_o)
);

// File: bench/id_stage_tb.sv
module id_stage_tb;
	timeunit 1ns;
	timeprecision 100ps;

	import id_pkg::*;

	typedef enum logic [1:0] {FMT_R, FMT_I, FMT_RI} fmt_e;
	typedef enum logic [2:0] {IMM_Z, IMM_ZX, IMM_SX, IMM_UP, IMM_SH} imm_e;
	typedef enum logic [1:0] {DST_RD, DST_RT, DST_LNK} dst_e;

	// one kept instruction with its expected decode
	typedef struct packed {
		fmt_e       fmt;
		logic [5:0] code;
		alu_op_e    op;
		alu_sel_e   sel;
		logic       rd1;
		logic       rd2;
		logic       we;
		imm_e       imm;
		dst_e       dst;
	} tmpl_t;

	logic      clk;
	logic      rst_n;
	logic      inst_valid;
	word_t     inst_word;
	word_t     pc;
	logic      in_delayslot;
	logic      reg1_read;
	reg_addr_t reg1_addr;
	logic      reg2_read;
	reg_addr_t reg2_addr;
	word_t     reg1_data;
	word_t     reg2_data;
	fwd_t      ex_fwd;
	fwd_t      mem_fwd;
	alu_op_e   ex_aluop;
	branch_t   branch;
	logic      stall;
	logic      ex_valid;
	id_ex_t    ex_out;

	word_t       rf [0:31];
	logic [31:0] rng_state = 32'h8f07_9bf8;
	int          n_inst = 400;
	int          errors = 0;
	int          stalls = 0;
	tmpl_t       tp;
	logic        bad;
	id_ex_t      exp_ex;
	branch_t     exp_br;
	logic        exp_stall;
	logic        exp_rd1;
	logic        exp_rd2;
	logic        exp_valid = 1'b0;
	id_ex_t      last_ex;
	logic        have_last = 1'b0;

	// register file answers in the same cycle
	assign reg1_data = rf[reg1_addr];
	assign reg2_data = rf[reg2_addr];

	id_stage UUT (
		.clk            (clk),
		.rst_n_i        (rst_n),
		.inst_valid_i   (inst_valid),
		.inst_i         (inst_word),
		.pc_i           (pc),
		.in_delayslot_i (in_delayslot),
		.reg1_read_o    (reg1_read),
		.reg1_addr_o    (reg1_addr),
		.reg2_read_o    (reg2_read),
		.reg2_addr_o    (reg2_addr),
		.reg1_data_i    (reg1_data),
		.reg2_data_i    (reg2_data),
		.ex_fwd_i       (ex_fwd),
		.mem_fwd_i      (mem_fwd),
		.ex_aluop_i     (ex_aluop),
		.branch_o       (branch),
		.stall_o        (stall),
		.ex_valid_o     (ex_valid),
		.ex_o           (ex_out)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	initial begin
		#(n_inst * 8 + 200);
		$display("watchdog expired at %0t, the test did not finish", $time);
		$display("** FAIL **");
		$finish;
	end

	//////////////////////////////////////////////////
	// random source and instruction table
	//////////////////////////////////////////////////

	function automatic logic [31:0] next_rand();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return rng_state;
	endfunction

	// upper bits only, the low LCG bits cycle fast
	function automatic int rand_below(input int n);
		logic [31:0] r;
		r = next_rand();
		return int'(r[31:8]) % n;
	endfunction

	function automatic tmpl_t template_at(input int i);
		tmpl_t t;
		t = '0;
		case (i)
			0:  t = '{FMT_R, FN_AND, ALU_AND, SEL_LOGIC, 1'b1, 1'b1, 1'b1, IMM_Z, DST_RD};
			1:  t = '{FMT_R, FN_OR, ALU_OR, SEL_LOGIC, 1'b1, 1'b1, 1'b1, IMM_Z, DST_RD};
			2:  t = '{FMT_R, FN_XOR, ALU_XOR, SEL_LOGIC, 1'b1, 1'b1, 1'b1, IMM_Z, DST_RD};
			3:  t = '{FMT_R, FN_NOR, ALU_NOR, SEL_LOGIC, 1'b1, 1'b1, 1'b1, IMM_Z, DST_RD};
			4:  t = '{FMT_R, FN_SLL, ALU_SLL, SEL_SHIFT, 1'b0, 1'b1, 1'b1, IMM_SH, DST_RD};
			5:  t = '{FMT_R, FN_SRL, ALU_SRL, SEL_SHIFT, 1'b0, 1'b1, 1'b1, IMM_SH, DST_RD};
			6:  t = '{FMT_R, FN_SRA, ALU_SRA, SEL_SHIFT, 1'b0, 1'b1, 1'b1, IMM_SH, DST_RD};
			7:  t = '{FMT_R, FN_SLLV, ALU_SLLV, SEL_SHIFT, 1'b1, 1'b1, 1'b1, IMM_Z, DST_RD};
			8:  t = '{FMT_R, FN_SRLV, ALU_SRLV, SEL_SHIFT, 1'b1, 1'b1, 1'b1, IMM_Z, DST_RD};
			9:  t = '{FMT_R, FN_SRAV, ALU_SRAV, SEL_SHIFT, 1'b1, 1'b1, 1'b1, IMM_Z, DST_RD};
			10: t = '{FMT_R, FN_ADD, ALU_ADD, SEL_ARITH, 1'b1, 1'b1, 1'b1, IMM_Z, DST_RD};
			11: t = '{FMT_R, FN_ADDU, ALU_ADDU, SEL_ARITH, 1'b1, 1'b1, 1'b1, IMM_Z, DST_RD};
			12: t = '{FMT_R, FN_SUB, ALU_SUB, SEL_ARITH, 1'b1, 1'b1, 1'b1, IMM_Z, DST_RD};
			13: t = '{FMT_R, FN_SUBU, ALU_SUBU, SEL_ARITH, 1'b1, 1'b1, 1'b1, IMM_Z, DST_RD};
			14: t = '{FMT_R, FN_SLT, ALU_SLT, SEL_ARITH, 1'b1, 1'b1, 1'b1, IMM_Z, DST_RD};
			15: t = '{FMT_R, FN_SLTU, ALU_SLTU, SEL_ARITH, 1'b1, 1'b1, 1'b1, IMM_Z, DST_RD};
			16: t = '{FMT_R, FN_JR, ALU_JR, SEL_JUMP_BRANCH, 1'b1, 1'b0, 1'b0, IMM_Z, DST_RD};
			17: t = '{FMT_R, FN_JALR, ALU_JALR, SEL_JUMP_BRANCH, 1'b1, 1'b0, 1'b1, IMM_Z, DST_RD};
			18: t = '{FMT_I, OP_J, ALU_J, SEL_JUMP_BRANCH, 1'b0, 1'b0, 1'b0, IMM_Z, DST_RT};
			19: t = '{FMT_I, OP_JAL, ALU_JAL, SEL_JUMP_BRANCH, 1'b0, 1'b0, 1'b1, IMM_Z, DST_LNK};
			20: t = '{FMT_I, OP_BEQ, ALU_BEQ, SEL_JUMP_BRANCH, 1'b1, 1'b1, 1'b0, IMM_Z, DST_RT};
			21: t = '{FMT_I, OP_BNE, ALU_BNE, SEL_JUMP_BRANCH, 1'b1, 1'b1, 1'b0, IMM_Z, DST_RT};
			22: t = '{FMT_I, OP_BLEZ, ALU_BLEZ, SEL_JUMP_BRANCH, 1'b1, 1'b0, 1'b0, IMM_Z, DST_RT};
			23: t = '{FMT_I, OP_BGTZ, ALU_BGTZ, SEL_JUMP_BRANCH, 1'b1, 1'b0, 1'b0, IMM_Z, DST_RT};
			24: t = '{FMT_I, OP_ANDI, ALU_ANDI, SEL_LOGIC, 1'b1, 1'b0, 1'b1, IMM_ZX, DST_RT};
			25: t = '{FMT_I, OP_ORI, ALU_ORI, SEL_LOGIC, 1'b1, 1'b0, 1'b1, IMM_ZX, DST_RT};
			26: t = '{FMT_I, OP_XORI, ALU_XORI, SEL_LOGIC, 1'b1, 1'b0, 1'b1, IMM_ZX, DST_RT};
			27: t = '{FMT_I, OP_LUI, ALU_LUI, SEL_LOGIC, 1'b1, 1'b0, 1'b1, IMM_UP, DST_RT};
			28: t = '{FMT_I, OP_ADDI, ALU_ADDI, SEL_ARITH, 1'b1, 1'b0, 1'b1, IMM_SX, DST_RT};
			29: t = '{FMT_I, OP_ADDIU, ALU_ADDIU, SEL_ARITH, 1'b1, 1'b0, 1'b1, IMM_SX, DST_RT};
			30: t = '{FMT_I, OP_SLTI, ALU_SLTI, SEL_ARITH, 1'b1, 1'b0, 1'b1, IMM_SX, DST_RT};
			31: t = '{FMT_I, OP_SLTIU, ALU_SLTIU, SEL_ARITH, 1'b1, 1'b0, 1'b1, IMM_SX, DST_RT};
			32: t = '{FMT_I, OP_LB, ALU_LB, SEL_LOAD_STORE, 1'b1, 1'b0, 1'b1, IMM_Z, DST_RT};
			33: t = '{FMT_I, OP_LBU, ALU_LBU, SEL_LOAD_STORE, 1'b1, 1'b0, 1'b1, IMM_Z, DST_RT};
			34: t = '{FMT_I, OP_LW, ALU_LW, SEL_LOAD_STORE, 1'b1, 1'b0, 1'b1, IMM_Z, DST_RT};
			35: t = '{FMT_I, OP_SB, ALU_SB, SEL_LOAD_STORE, 1'b1, 1'b1, 1'b0, IMM_Z, DST_RT};
			36: t = '{FMT_I, OP_SW, ALU_SW, SEL_LOAD_STORE, 1'b1, 1'b1, 1'b0, IMM_Z, DST_RT};
			37: t = '{FMT_RI, RI_BLTZ, ALU_BLTZ, SEL_JUMP_BRANCH, 1'b1, 1'b0, 1'b0, IMM_Z, DST_RT};
			38: t = '{FMT_RI, RI_BGEZ, ALU_BGEZ, SEL_JUMP_BRANCH, 1'b1, 1'b0, 1'b0, IMM_Z, DST_RT};
			39: t = '{FMT_RI, RI_BLTZAL, ALU_BLTZAL, SEL_JUMP_BRANCH, 1'b1, 1'b0, 1'b1, IMM_Z,
				DST_LNK};
			40: t = '{FMT_RI, RI_BGEZAL, ALU_BGEZAL, SEL_JUMP_BRANCH, 1'b1, 1'b0, 1'b1, IMM_Z,
				DST_LNK};
			default: ;
		endcase
		return t;
	endfunction

	// write port aimed at rs, rt or anywhere
	function automatic fwd_t make_fwd(input reg_addr_t rs, input reg_addr_t rt);
		fwd_t        f;
		logic [31:0] r;
		r = next_rand();
		f.we = r[20];
		case (r[25:24])
			2'd0:    f.waddr = rs;
			2'd1:    f.waddr = rt;
			default: f.waddr = r[4:0];
		endcase
		f.wdata = next_rand();
		return f;
	endfunction

	task automatic new_stimulus();
		int          idx;
		logic [31:0] r;
		logic [31:0] r2;
		idx = rand_below(44);
		r   = next_rand();
		r2  = next_rand();
		bad = (idx >= 41);
		tp  = template_at(bad ? 0 : idx);
		// 41 to 43 are encodings outside the kept set
		if (idx == 41) begin
			inst_word = {6'b011100, r[25:0]};
		end else if (idx == 42) begin
			inst_word = {6'b000000, r[25:6], 6'b011000};
		end else if (idx == 43) begin
			inst_word = {6'b000001, r[25:21], 5'b00011, r[15:0]};
		end else if (tp.fmt == FMT_R) begin
			inst_word = {6'b000000, r[25:6], tp.code};
		end else if (tp.fmt == FMT_I) begin
			inst_word = {tp.code, r[25:0]};
		end else begin
			inst_word = {6'b000001, r[25:21], tp.code[4:0], r[15:0]};
		end
		// same register on both ports so BEQ/BNE see equal operands
		if (!bad && (tp.op inside {ALU_BEQ, ALU_BNE}) && r2[0]) begin
			inst_word[20:16] = inst_word[25:21];
		end
		pc           = {r2[31:2], 2'b00};
		in_delayslot = r[31];
		ex_fwd       = make_fwd(inst_word[25:21], inst_word[20:16]);
		mem_fwd      = make_fwd(inst_word[25:21], inst_word[20:16]);
		case (rand_below(8))
			0:       ex_aluop = ALU_LW;
			1:       ex_aluop = ALU_LB;
			2:       ex_aluop = ALU_LBU;
			default: ex_aluop = ALU_ADDU;
		endcase
		inst_valid = 1'b1;
	endtask

	//////////////////////////////////////////////////
	// reference model
	//////////////////////////////////////////////////

	function automatic word_t operand_model(input logic rd_en, input reg_addr_t a,
		input word_t imm);
		word_t v;
		if (!rd_en) begin
			v = imm;
		end else if (ex_fwd.we && ex_fwd.waddr == a) begin
			v = ex_fwd.wdata;
		end else if (mem_fwd.we && mem_fwd.waddr == a) begin
			v = mem_fwd.wdata;
		end else begin
			v = rf[a];
		end
		return v;
	endfunction

	task automatic predict();
		word_t imm;
		word_t pc4;
		word_t tgt;
		logic  taken;
		logic  ld_hit;
		exp_rd1 = !bad && tp.rd1;
		exp_rd2 = !bad && tp.rd2;
		case (tp.imm)
			IMM_ZX:  imm = {16'h0000, inst_word[15:0]};
			IMM_SX:  imm = {{16{inst_word[15]}}, inst_word[15:0]};
			IMM_UP:  imm = {inst_word[15:0], 16'h0000};
			IMM_SH:  imm = {27'd0, inst_word[10:6]};
			default: imm = '0;
		endcase
		if (bad) begin
			imm = '0;
		end
		exp_ex.alu_op  = bad ? ALU_NOP : tp.op;
		exp_ex.alu_sel = bad ? SEL_NOP : tp.sel;
		exp_ex.reg1    = operand_model(exp_rd1, inst_word[25:21], imm);
		exp_ex.reg2    = operand_model(exp_rd2, inst_word[20:16], imm);
		exp_ex.we      = !bad && tp.we;
		case (tp.dst)
			DST_RD:  exp_ex.waddr = inst_word[15:11];
			DST_RT:  exp_ex.waddr = inst_word[20:16];
			default: exp_ex.waddr = 5'd31;
		endcase
		exp_ex.in_delayslot = in_delayslot;
		exp_ex.invalid      = bad;
		exp_ex.inst         = inst_word;
		pc4   = pc + 32'd4;
		tgt   = pc4 + {{14{inst_word[15]}}, inst_word[15:0], 2'b00};
		taken = 1'b0;
		case (exp_ex.alu_op)
			ALU_J, ALU_JAL: begin
				taken = 1'b1;
				tgt   = {pc4[31:28], inst_word[25:0], 2'b00};
			end
			ALU_JR, ALU_JALR: begin
				taken = 1'b1;
				tgt   = exp_ex.reg1;
			end
			ALU_BEQ:              taken = (exp_ex.reg1 == exp_ex.reg2);
			ALU_BNE:              taken = (exp_ex.reg1 != exp_ex.reg2);
			ALU_BGTZ:             taken = ($signed(exp_ex.reg1) > 0);
			ALU_BLEZ:             taken = ($signed(exp_ex.reg1) <= 0);
			ALU_BGEZ, ALU_BGEZAL: taken = !exp_ex.reg1[31];
			ALU_BLTZ, ALU_BLTZAL: taken = exp_ex.reg1[31];
			default:              taken = 1'b0;
		endcase
		exp_ex.link_addr = '0;
		if (exp_ex.alu_op inside {ALU_JAL, ALU_JALR, ALU_BGEZAL, ALU_BLTZAL}) begin
			exp_ex.link_addr = pc + 32'd8;
		end
		ld_hit = (exp_rd1 && ex_fwd.waddr == inst_word[25:21]) ||
			(exp_rd2 && ex_fwd.waddr == inst_word[20:16]);
		exp_stall = (ex_aluop inside {ALU_LB, ALU_LBU, ALU_LW}) && ex_fwd.we && ld_hit;
		exp_br.flag              = taken && !exp_stall;
		exp_br.target            = taken ? tgt : '0;
		exp_br.link_addr         = exp_ex.link_addr;
		exp_br.next_in_delayslot = exp_br.flag;
	endtask

	//////////////////////////////////////////////////
	// checks
	//////////////////////////////////////////////////

	task automatic report_mismatch(input string name, input logic [31:0] got,
		input logic [31:0] want);
		errors++;
		$display("FAILED at %0t: %s is %h, expected %h", $time, name, got, want);
	endtask

	// same-cycle outputs of the strobe
	task automatic check_comb();
		if (stall !== exp_stall) report_mismatch("stall_o", stall, exp_stall);
		if (branch.flag !== exp_br.flag) report_mismatch("branch_o.flag", branch.flag,
			exp_br.flag);
		if (branch.target !== exp_br.target) report_mismatch("branch_o.target",
			branch.target, exp_br.target);
		if (branch.link_addr !== exp_br.link_addr) report_mismatch("branch_o.link_addr",
			branch.link_addr, exp_br.link_addr);
		if (branch.next_in_delayslot !== exp_br.next_in_delayslot)
			report_mismatch("branch_o.next_in_delayslot", branch.next_in_delayslot,
				exp_br.next_in_delayslot);
		if (reg1_read !== exp_rd1) report_mismatch("reg1_read_o", reg1_read, exp_rd1);
		if (reg2_read !== exp_rd2) report_mismatch("reg2_read_o", reg2_read, exp_rd2);
		if (exp_rd1 && reg1_addr !== inst_word[25:21]) report_mismatch("reg1_addr_o",
			reg1_addr, inst_word[25:21]);
		if (exp_rd2 && reg2_addr !== inst_word[20:16]) report_mismatch("reg2_addr_o",
			reg2_addr, inst_word[20:16]);
	endtask

	// ID/EX contents one cycle after the strobe
	task automatic tick_and_check();
		@(posedge clk);
		#1;
		if (ex_valid !== exp_valid) report_mismatch("ex_valid_o", ex_valid, exp_valid);
		if (exp_valid) begin
			if (ex_out.alu_op !== exp_ex.alu_op) report_mismatch("ex_o.alu_op",
				ex_out.alu_op, exp_ex.alu_op);
			if (ex_out.alu_sel !== exp_ex.alu_sel) report_mismatch("ex_o.alu_sel",
				ex_out.alu_sel, exp_ex.alu_sel);
			if (ex_out.reg1 !== exp_ex.reg1) report_mismatch("ex_o.reg1", ex_out.reg1,
				exp_ex.reg1);
			if (ex_out.reg2 !== exp_ex.reg2) report_mismatch("ex_o.reg2", ex_out.reg2,
				exp_ex.reg2);
			if (ex_out.we !== exp_ex.we) report_mismatch("ex_o.we", ex_out.we, exp_ex.we);
			if (exp_ex.we && ex_out.waddr !== exp_ex.waddr) report_mismatch("ex_o.waddr",
				ex_out.waddr, exp_ex.waddr);
			if (ex_out.link_addr !== exp_ex.link_addr) report_mismatch("ex_o.link_addr",
				ex_out.link_addr, exp_ex.link_addr);
			if (ex_out.in_delayslot !== exp_ex.in_delayslot) report_mismatch(
				"ex_o.in_delayslot", ex_out.in_delayslot, exp_ex.in_delayslot);
			if (ex_out.invalid !== exp_ex.invalid) report_mismatch("ex_o.invalid",
				ex_out.invalid, exp_ex.invalid);
			if (ex_out.inst !== exp_ex.inst) report_mismatch("ex_o.inst", ex_out.inst,
				exp_ex.inst);
			last_ex   = ex_out;
			have_last = 1'b1;
		end else if (have_last && ex_out !== last_ex) begin
			errors++;
			$display("ex_o changed at %0t while ex_valid_o was low", $time);
		end
		exp_valid  = 1'b0;
		inst_valid = 1'b0;
	endtask

	initial begin
		rst_n        = 1'b0;
		inst_valid   = 1'b0;
		inst_word    = '0;
		pc           = '0;
		in_delayslot = 1'b0;
		ex_fwd       = '0;
		mem_fwd      = '0;
		ex_aluop     = ALU_NOP;
		for (int i = 0; i < 32; i++) begin
			rf[i] = next_rand();
		end
		repeat (5) @(posedge clk);
		#1;
		rst_n = 1'b1;

		// idle after reset
		repeat (3) begin
			tick_and_check();
			if (ex_valid !== 1'b0 || branch.flag !== 1'b0 || stall !== 1'b0) begin
				errors++;
				$display("outputs not idle after reset at %0t", $time);
			end
		end

		for (int n = 0; n < n_inst; n++) begin
			if (rand_below(4) == 0) begin
				tick_and_check();
			end
			tick_and_check();
			new_stimulus();
			#1;
			predict();
			check_comb();
			// replay the load-use victim once the load has moved on
			if (exp_stall) begin
				stalls++;
				tick_and_check();
				inst_valid = 1'b1;
				ex_aluop   = ALU_NOP;
				#1;
				predict();
				check_comb();
			end
			exp_valid = 1'b1;
		end
		tick_and_check();

		errors += UUT.u_chk.fail_count;
		$display("%0d instructions, %0d stalls, %0d errors", n_inst, stalls, errors);
		if (errors == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

// File: id_stage.f
source/id_pkg.sv
source/inst_decoder.sv
source/operand_bypass.sv
source/branch_resolver.sv
source/id_stage.sv
bench/id_stage_chk.sv
bench/id_stage_tb.sv
